/* rtl/uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // ----------------------------------------
  // Character format
  // ----------------------------------------

  // Stored character width, upper bits zero for short words
  localparam int unsigned CHAR_W = 8;

  // Data bits per character
  typedef enum logic [1:0] {
    WLEN_5 = 2'b00,
    WLEN_6 = 2'b01,
    WLEN_7 = 2'b10,
    WLEN_8 = 2'b11
  } word_len_e;

  // Parity bit handling
  typedef enum logic [2:0] {
    PAR_NONE  = 3'b000, // No parity bit on the line
    PAR_ODD   = 3'b001,
    PAR_EVEN  = 3'b010,
    PAR_MARK  = 3'b011, // Parity bit forced 1
    PAR_SPACE = 3'b100  // Parity bit forced 0
  } parity_e;

  // ----------------------------------------
  // Receive FIFO
  // ----------------------------------------

  // Fill level that raises the trigger
  typedef enum logic [1:0] {
    TRIG_1  = 2'b00,
    TRIG_4  = 2'b01,
    TRIG_8  = 2'b10,
    TRIG_14 = 2'b11
  } rx_trig_e;

endpackage

/* rtl/uart_rx_pkg.sv */
package uart_rx_pkg;

  // ----------------------------------------
  // Oversampling
  // ----------------------------------------

  localparam int unsigned OVS_RATE   = 16; // Ticks per bit
  localparam int unsigned OVS_CNT_W  = 4;  // Bit timer width
  localparam int unsigned BIT_CENTER = 8;  // Last majority sample, strobe point

  // Majority window
  localparam int unsigned MAJ_CLEAR  = 5;  // Sample counter cleared here
  localparam int unsigned MAJ_FIRST  = 6;  // First of three samples

  // ----------------------------------------
  // Frame decoder
  // ----------------------------------------

  // Index into the receive shift register
  localparam int unsigned BIT_IDX_W  = 3;

  // Frame FSM
  typedef enum logic [1:0] {
    RX_IDLE   = 2'b00, // Waiting for a start sample
    RX_DATA   = 2'b01,
    RX_PARITY = 2'b10,
    RX_STOP   = 2'b11
  } rx_state_e;

endpackage

/* rtl/rx_sampler.sv */
`timescale 1ns/10ps

module rx_sampler #(
  parameter int unsigned CLKS_PER_TICK = 4,
  parameter int unsigned SYNC_STAGES   = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic rxd_i,
  input  logic frame_active_i,
  output logic bit_center_o,
  output logic bit_value_o
);

  import uart_rx_pkg::*;

  // Divider width, one bit minimum
  localparam int unsigned DIV_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   rxd_sync;

  logic [DIV_W-1:0]       div_q;
  logic                   tick;

  logic [OVS_CNT_W-1:0]   timer_q, timer_d;
  logic                   timer_hold;

  logic [1:0]             high_cnt_q, high_cnt_d;
  logic                   center_hit;
  logic                   majority;

  // ----------------------------------------
  // Input synchronizer
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '1; // Line idles high
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign rxd_sync = sync_q[SYNC_STAGES-1];

  // ----------------------------------------
  // Oversample tick
  // ----------------------------------------

  // Free running, so start phase jitters by up to one tick
  assign tick = (div_q == DIV_W'(CLKS_PER_TICK - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_q <= '0;
    end else if (tick) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // ----------------------------------------
  // Bit timer and majority filter
  // ----------------------------------------

  // Parked at zero on an idle high line
  assign timer_hold = !frame_active_i && rxd_sync;

  always_comb begin
    timer_d    = timer_q;
    high_cnt_d = high_cnt_q;
    if (timer_hold) begin
      timer_d = '0;
    end else if (tick) begin
      if (timer_q == OVS_CNT_W'(OVS_RATE - 1)) begin
        timer_d = '0; // Wrap into the next bit
      end else begin
        timer_d = timer_q + 1'b1;
      end
      // Window 6..8, counted on the tick entering each count
      if (timer_d == OVS_CNT_W'(MAJ_CLEAR)) begin
        high_cnt_d = '0;
      end else if (timer_d >= OVS_CNT_W'(MAJ_FIRST) && timer_d <= OVS_CNT_W'(BIT_CENTER)) begin
        high_cnt_d = high_cnt_q + {1'b0, rxd_sync};
      end
    end
  end

  // Reaching the center only happens on a counting tick
  assign center_hit = !timer_hold && tick && (timer_d == OVS_CNT_W'(BIT_CENTER));
  assign majority   = high_cnt_d[1]; // Two or three high samples

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      timer_q      <= '0;
      high_cnt_q   <= '0;
      bit_center_o <= 1'b0;
    end else begin
      timer_q      <= timer_d;
      high_cnt_q   <= high_cnt_d;
      bit_center_o <= center_hit; // One clock wide
    end
  end

  // Sampled value, qualified by the strobe
  always_ff @(posedge clk_i) begin
    if (center_hit) begin
      bit_value_o <= majority;
    end
  end

endmodule

/* rtl/rx_frame_decoder.sv */
`timescale 1ns/10ps

module rx_frame_decoder (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          bit_center_i,
  input  logic                          bit_value_i,
  input  uart_cfg_pkg::word_len_e       word_len_i,
  input  uart_cfg_pkg::parity_e         parity_i,
  output logic                          frame_active_o,
  output logic                          char_valid_o,
  output logic [uart_cfg_pkg::CHAR_W-1:0] char_data_o,
  output logic                          char_parity_err_o,
  output logic                          char_frame_err_o,
  output logic                          char_break_o
);

  import uart_cfg_pkg::*;
  import uart_rx_pkg::*;

  rx_state_e              state_q, state_d;
  logic [BIT_IDX_W-1:0]   bit_idx_q, bit_idx_d;
  logic [BIT_IDX_W-1:0]   last_idx;

  logic [CHAR_W-1:0]      shift_q;   // Receive shift register
  logic                   ones_q;    // Any 1 seen in data or parity
  logic                   par_err_q;
  logic                   par_err_d;
  logic                   data_par;

  // ----------------------------------------
  // Word length decode
  // ----------------------------------------

  always_comb begin
    case (word_len_i)
      WLEN_5:  last_idx = BIT_IDX_W'(4);
      WLEN_6:  last_idx = BIT_IDX_W'(5);
      WLEN_7:  last_idx = BIT_IDX_W'(6);
      default: last_idx = BIT_IDX_W'(7);
    endcase
  end

  // ----------------------------------------
  // Frame FSM
  // ----------------------------------------

  always_comb begin
    state_d   = state_q;
    bit_idx_d = bit_idx_q;
    case (state_q)
      RX_IDLE: begin
        // High sample is a false start, stay here
        if (bit_center_i && !bit_value_i) begin
          state_d   = RX_DATA;
          bit_idx_d = '0;
        end
      end
      RX_DATA: begin
        if (bit_center_i) begin
          bit_idx_d = bit_idx_q + 1'b1;
          if (bit_idx_q == last_idx) begin
            state_d = (parity_i == PAR_NONE) ? RX_STOP : RX_PARITY;
          end
        end
      end
      RX_PARITY: begin
        if (bit_center_i) begin
          state_d = RX_STOP;
        end
      end
      RX_STOP: begin
        if (bit_center_i) begin
          state_d = RX_IDLE; // Low line here keeps the timer running
        end
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      bit_idx_q <= '0;
    end else begin
      state_q   <= state_d;
      bit_idx_q <= bit_idx_d;
    end
  end

  // ----------------------------------------
  // Parity check
  // ----------------------------------------

  assign data_par = ^shift_q; // Unused upper bits are zero

  always_comb begin
    case (parity_i)
      PAR_ODD:   par_err_d = ~(data_par ^ bit_value_i); // Even count of ones
      PAR_EVEN:  par_err_d = data_par ^ bit_value_i;
      PAR_MARK:  par_err_d = ~bit_value_i;
      PAR_SPACE: par_err_d = bit_value_i;
      default:   par_err_d = 1'b0;
    endcase
  end

  // Character payload
  always_ff @(posedge clk_i) begin
    if (bit_center_i) begin
      case (state_q)
        RX_IDLE: begin
          shift_q   <= '0;
          ones_q    <= 1'b0;
          par_err_q <= 1'b0; // Stays clear with PAR_NONE
        end
        RX_DATA: begin
          shift_q[bit_idx_q] <= bit_value_i; // LSB first
          ones_q             <= ones_q | bit_value_i;
        end
        RX_PARITY: begin
          par_err_q <= par_err_d;
          ones_q    <= ones_q | bit_value_i;
        end
        default: begin
          ones_q <= ones_q;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign frame_active_o    = (state_q != RX_IDLE);
  assign char_valid_o      = bit_center_i && (state_q == RX_STOP); // Stop-bit center
  assign char_data_o       = shift_q;
  assign char_parity_err_o = par_err_q;
  assign char_frame_err_o  = ~bit_value_i; // Stop sample low
  assign char_break_o      = ~(ones_q | bit_value_i); // Whole frame low

endmodule

/* rtl/rx_char_fifo.sv */
`timescale 1ns/10ps

module rx_char_fifo #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            char_valid_i,
  input  logic [uart_cfg_pkg::CHAR_W-1:0] char_data_i,
  input  logic                            char_parity_err_i,
  input  logic                            char_frame_err_i,
  input  logic                            char_break_i,
  input  logic                            rd_en_i,
  input  logic                            flush_i,
  input  uart_cfg_pkg::rx_trig_e          trig_level_i,
  output logic [uart_cfg_pkg::CHAR_W-1:0] rd_data_o,
  output logic                            rd_parity_err_o,
  output logic                            rd_frame_err_o,
  output logic                            rd_break_o,
  output logic                            data_ready_o,
  output logic                            trigger_o,
  output logic                            overrun_o
);

  import uart_cfg_pkg::*;

  localparam int unsigned ENTRY_W = CHAR_W + 3;                 // Flags on top of data
  localparam int unsigned PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W   = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned CMP_W   = (CNT_W > 4) ? CNT_W : 4;    // Room for 14

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               full, empty;
  logic               push, pop;
  logic [CMP_W-1:0]   trig_chars;

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // Flush wins over both sides
  assign push = char_valid_i && !full && !flush_i;
  assign pop  = rd_en_i && !empty && !flush_i; // Empty read ignored

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= {char_parity_err_i, char_frame_err_i, char_break_i, char_data_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Character lost on a full FIFO
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      overrun_o <= 1'b0;
    end else begin
      overrun_o <= char_valid_i && full && !flush_i;
    end
  end

  // ----------------------------------------
  // Head and status
  // ----------------------------------------

  assign {rd_parity_err_o, rd_frame_err_o, rd_break_o, rd_data_o} = mem[rd_ptr_q];
  assign data_ready_o = !empty;

  always_comb begin
    case (trig_level_i)
      TRIG_1:  trig_chars = CMP_W'(1);
      TRIG_4:  trig_chars = CMP_W'(4);
      TRIG_8:  trig_chars = CMP_W'(8);
      default: trig_chars = CMP_W'(14);
    endcase
  end

  assign trigger_o = (CMP_W'(count_q) >= trig_chars);

endmodule

/* rtl/uart_rx_top.sv */
`timescale 1ns/10ps

module uart_rx_top #(
  parameter int unsigned CLKS_PER_TICK = 4,
  parameter int unsigned SYNC_STAGES   = 2,
  parameter int unsigned FIFO_DEPTH    = 16
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            rxd_i,
  input  uart_cfg_pkg::word_len_e         word_len_i,
  input  uart_cfg_pkg::parity_e           parity_i,
  input  uart_cfg_pkg::rx_trig_e          trig_level_i,
  input  logic                            rd_en_i,
  input  logic                            flush_i,
  output logic [uart_cfg_pkg::CHAR_W-1:0] rd_data_o,
  output logic                            rd_parity_err_o,
  output logic                            rd_frame_err_o,
  output logic                            rd_break_o,
  output logic                            data_ready_o,
  output logic                            trigger_o,
  output logic                            overrun_o
);

  import uart_cfg_pkg::*;

  // Sampler and decoder handshake
  logic              bit_center;
  logic              bit_value;
  logic              frame_active;

  // Decoded character
  logic              char_valid;
  logic [CHAR_W-1:0] char_data;
  logic              char_parity_err;
  logic              char_frame_err;
  logic              char_break;

  // ----------------------------------------
  // Receive pipeline
  // ----------------------------------------

  rx_sampler #(
    .CLKS_PER_TICK (CLKS_PER_TICK),
    .SYNC_STAGES   (SYNC_STAGES)
  ) u_sampler (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rxd_i          (rxd_i),
    .frame_active_i (frame_active),
    .bit_center_o   (bit_center),
    .bit_value_o    (bit_value)
  );

  rx_frame_decoder u_decoder (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .bit_center_i      (bit_center),
    .bit_value_i       (bit_value),
    .word_len_i        (word_len_i),
    .parity_i          (parity_i),
    .frame_active_o    (frame_active),
    .char_valid_o      (char_valid),
    .char_data_o       (char_data),
    .char_parity_err_o (char_parity_err),
    .char_frame_err_o  (char_frame_err),
    .char_break_o      (char_break)
  );

  rx_char_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .char_valid_i      (char_valid),
    .char_data_i       (char_data),
    .char_parity_err_i (char_parity_err),
    .char_frame_err_i  (char_frame_err),
    .char_break_i      (char_break),
    .rd_en_i           (rd_en_i),
    .flush_i           (flush_i),
    .trig_level_i      (trig_level_i),
    .rd_data_o         (rd_data_o),
    .rd_parity_err_o   (rd_parity_err_o),
    .rd_frame_err_o    (rd_frame_err_o),
    .rd_break_o        (rd_break_o),
    .data_ready_o      (data_ready_o),
    .trigger_o         (trigger_o),
    .overrun_o         (overrun_o)
  );

endmodule

/* include/uart_tb_tasks.svh */
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// ----------------------------------------
// Frame model
// ----------------------------------------

// Data bits per word length code
function automatic int data_bits(input word_len_e wlen);
  return 5 + int'(wlen);
endfunction

// Upper bits beyond the word length cleared
function automatic logic [7:0] masked(input logic [7:0] data, input word_len_e wlen);
  return data & 8'((1 << data_bits(wlen)) - 1);
endfunction

// Parity bit a correct sender puts on the line
function automatic logic parity_bit(input logic [7:0] data, input parity_e par);
  case (par)
    PAR_ODD:  return ~(^data); // Total ones made odd
    PAR_EVEN: return ^data;
    PAR_MARK: return 1'b1;
    default:  return 1'b0;
  endcase
endfunction

// Error rule per mode, on the bit actually sent
function automatic logic parity_error(input logic [7:0] data, input logic pbit,
                                      input parity_e par);
  logic odd_total;
  odd_total = (^data) ^ pbit;
  case (par)
    PAR_ODD:   return ~odd_total; // Even count is wrong
    PAR_EVEN:  return odd_total;
    PAR_MARK:  return ~pbit;
    PAR_SPACE: return pbit;
    default:   return 1'b0;
  endcase
endfunction

// Queue the expected entry, or count a discard on a full FIFO
task automatic expect_char(input logic [7:0] data, input word_len_e wlen, input parity_e par,
                           input logic pbit, input logic stop);
  logic [7:0] d;
  logic       perr;
  logic       ferr;
  logic       brk;
  d    = masked(data, wlen);
  perr = parity_error(d, pbit, par);
  ferr = ~stop;
  brk  = (d == 8'h00) && (par == PAR_NONE || !pbit) && !stop; // Whole frame low
  if (exp_q.size() < FIFO_DEPTH) begin
    exp_q.push_back({perr, ferr, brk, d});
  end else begin
    exp_overruns++;
  end
endtask

// ----------------------------------------
// Line driver
// ----------------------------------------

task automatic drive_bit(input logic value);
  rxd = value;
  repeat (BIT_CLKS) @(negedge clk);
endtask

// Start, data LSB first, optional parity, stop, then a short idle gap
task automatic send_frame(input logic [7:0] data, input word_len_e wlen, input parity_e par,
                          input logic flip_par, input logic stop);
  logic [7:0] d;
  logic       pbit;
  int         gap;
  d    = masked(data, wlen);
  pbit = parity_bit(d, par) ^ flip_par; // Inverted on request
  expect_char(data, wlen, par, pbit, stop);
  word_len = wlen;
  parity   = par;
  drive_bit(1'b0);
  for (int i = 0; i < data_bits(wlen); i++) begin
    drive_bit(d[i]);
  end
  if (par != PAR_NONE) begin
    drive_bit(pbit);
  end
  drive_bit(stop);
  rxd = 1'b1;
  gap = $urandom_range(0, BIT_CLKS - 1); // Fraction of a bit
  repeat (gap) @(negedge clk);
endtask

// ----------------------------------------
// Checking
// ----------------------------------------

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] expv);
  check_count++;
  if (got !== expv) begin
    error_count++;
    $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, expv);
  end
endtask

// Wait for the head, compare it with the model, then pop it
task automatic read_char(input string what);
  logic [10:0] entry;
  int          waited;
  waited = 0;
  while (!data_ready && waited < 2 * FRAME_CLKS) begin
    @(negedge clk);
    waited++;
  end
  if (exp_q.size() == 0) begin
    error_count++;
    $display("Read of %s found no expected character in the model", what);
  end else if (!data_ready) begin
    error_count++;
    void'(exp_q.pop_front()); // Keep the model in step
    $display("Read of %s gave up, data_ready_o never rose within two frame times", what);
  end else begin
    entry = exp_q.pop_front();
    check_value({what, " data"}, 32'(rd_data), 32'(entry[7:0]));
    check_value({what, " parity flag"}, 32'(rd_parity_err), 32'(entry[10]));
    check_value({what, " framing flag"}, 32'(rd_frame_err), 32'(entry[9]));
    check_value({what, " break flag"}, 32'(rd_break), 32'(entry[8]));
    rd_en = 1'b1;
    @(negedge clk);
    rd_en = 1'b0;
  end
endtask

`endif

/* test/tb_uart_rx.sv */
`timescale 1ns/10ps

module tb_uart_rx;

  import uart_cfg_pkg::*;

  localparam int CLKS_PER_TICK = 4;
  localparam int FIFO_DEPTH    = 16;
  localparam int CLK_PERIOD    = 100;
  localparam int BIT_CLKS      = 16 * CLKS_PER_TICK; // 64 clocks per bit
  localparam int FRAME_CLKS    = 12 * BIT_CLKS;
  localparam int N_RANDOM      = 24;

  // Glitch wait counts as two frames
  localparam int TOTAL_FRAMES  = N_RANDOM + 8 + 3 + 27 + 18 + 2;
  localparam longint WATCHDOG_NS = 2 * longint'(TOTAL_FRAMES) * FRAME_CLKS * CLK_PERIOD;

  logic              clk;
  logic              rst_n;
  logic              rxd;
  word_len_e         word_len;
  parity_e           parity;
  rx_trig_e          trig_level;
  logic              rd_en;
  logic              flush;
  logic [CHAR_W-1:0] rd_data;
  logic              rd_parity_err;
  logic              rd_frame_err;
  logic              rd_break;
  logic              data_ready;
  logic              trigger;
  logic              overrun;

  // Model mirror of the FIFO as {parity, framing, break, data}
  logic [10:0] exp_q[$];
  int          exp_overruns;
  int          overruns_seen;
  int          check_count;
  int          error_count;
  int          test_checks;  // Counts at start of current test
  int          test_errors;

  `include "uart_tb_tasks.svh"

  uart_rx_top #(
    .CLKS_PER_TICK (CLKS_PER_TICK),
    .SYNC_STAGES   (2),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) DUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .rxd_i           (rxd),
    .word_len_i      (word_len),
    .parity_i        (parity),
    .trig_level_i    (trig_level),
    .rd_en_i         (rd_en),
    .flush_i         (flush),
    .rd_data_o       (rd_data),
    .rd_parity_err_o (rd_parity_err),
    .rd_frame_err_o  (rd_frame_err),
    .rd_break_o      (rd_break),
    .data_ready_o    (data_ready),
    .trigger_o       (trigger),
    .overrun_o       (overrun)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Overrun is a one-clock pulse
  always @(negedge clk) begin
    if (rst_n && overrun) begin
      overruns_seen++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0t before all tests finished", $time);
    $display("ERRORS FOUND");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             check_count - test_checks, error_count - test_errors);
    test_checks = check_count;
    test_errors = error_count;
  endtask

  task automatic flush_fifo();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    exp_q.delete(); // Model empties too
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    logic [7:0] data;
    word_len_e  wlen;
    int         level;
    int         glitch_ready;
    void'($urandom(76714));
    clk           = 1'b0;
    rst_n         = 1'b0;
    rxd           = 1'b1; // Idle line
    word_len      = WLEN_8;
    parity        = PAR_NONE;
    trig_level    = TRIG_1;
    rd_en         = 1'b0;
    flush         = 1'b0;
    exp_overruns  = 0;
    overruns_seen = 0;
    check_count   = 0;
    error_count   = 0;
    test_checks   = 0;
    test_errors   = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // Clean random frames
    for (int i = 0; i < N_RANDOM; i++) begin
      data = 8'($urandom);
      wlen = word_len_e'($urandom_range(0, 3));
      send_frame(data, wlen, parity_e'($urandom_range(0, 4)), 1'b0, 1'b1);
      read_char("random character");
    end
    end_test(1, "random characters");

    // Each parity mode with correct and inverted parity bit
    for (int m = 1; m <= 4; m++) begin
      for (int f = 0; f < 2; f++) begin
        data = 8'($urandom);
        wlen = word_len_e'($urandom_range(0, 3));
        send_frame(data, wlen, parity_e'(m), 1'(f), 1'b1);
        read_char("parity character");
      end
    end
    end_test(2, "parity errors");

    send_frame(8'($urandom_range(1, 255)), WLEN_8, PAR_ODD, 1'b0, 1'b0); // Stop low
    read_char("framing error character");
    send_frame(8'h00, WLEN_8, PAR_EVEN, 1'b0, 1'b0); // All zero frame
    read_char("break character");
    send_frame(8'($urandom), WLEN_7, PAR_NONE, 1'b0, 1'b1);
    read_char("character after break");
    end_test(3, "framing and break");

    // Fill up to each trigger level without reads
    for (int t = 0; t < 4; t++) begin
      trig_level = rx_trig_e'(t);
      level = (t == 0) ? 1 : (t == 1) ? 4 : (t == 2) ? 8 : 14;
      for (int n = 1; n <= level; n++) begin
        send_frame(8'($urandom), WLEN_8, PAR_NONE, 1'b0, 1'b1);
        check_value("data_ready_o while filling", 32'(data_ready), 32'd1);
        check_value("trigger_o", 32'(trigger), 32'(n >= level));
      end
      flush_fifo();
      check_value("trigger_o after flush", 32'(trigger), 32'd0);
    end
    end_test(4, "trigger levels");

    // One character more than the FIFO holds
    for (int n = 0; n <= FIFO_DEPTH; n++) begin
      send_frame(8'($urandom), WLEN_8, PAR_NONE, 1'b0, 1'b1);
    end
    check_value("overrun_o pulse count", 32'(overruns_seen), 32'(exp_overruns));
    for (int n = 0; n < FIFO_DEPTH; n++) begin
      read_char("overrun fill character");
    end
    check_value("data_ready_o after drain", 32'(data_ready), 32'd0);
    send_frame(8'($urandom), WLEN_8, PAR_NONE, 1'b0, 1'b1);
    check_value("data_ready_o before flush", 32'(data_ready), 32'd1);
    flush_fifo();
    check_value("data_ready_o after flush", 32'(data_ready), 32'd0);
    end_test(5, "overrun and flush");

    // Two-tick low pulse on an idle line
    glitch_ready = 0;
    rxd = 1'b0;
    repeat (2 * CLKS_PER_TICK) @(negedge clk);
    rxd = 1'b1;
    repeat (2 * FRAME_CLKS) begin
      @(negedge clk);
      if (data_ready) begin
        glitch_ready++;
      end
    end
    check_value("data_ready_o cycles after glitch", 32'(glitch_ready), 32'd0);
    end_test(6, "glitch rejection");

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* uart_rx.f */
+incdir+include
rtl/uart_cfg_pkg.sv
rtl/uart_rx_pkg.sv
rtl/rx_sampler.sv
rtl/rx_frame_decoder.sv
rtl/rx_char_fifo.sv
rtl/uart_rx_top.sv
test/tb_uart_rx.sv

/* Makefile */
# Verilator build and run for the UART receive path

VERILATOR ?= verilator
TOP       ?= tb_uart_rx
FILELIST  ?= uart_rx.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= NO ERRORS

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv test/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
